// ==== graphics_processor.f ====
gp_cmd_pkg.sv
gp_mem_pkg.sv
gp_cmd_fetch.sv
gp_cmd_decode.sv
gp_cmd_execute.sv
graphics_processor.sv
tb_gp_models.sv
tb_graphics_processor.sv

// ==== Bender.yml ====
package:
  name: graphics_processor

sources:
  - gp_cmd_pkg.sv
  - gp_mem_pkg.sv
  - gp_cmd_fetch.sv
  - gp_cmd_decode.sv
  - gp_cmd_execute.sv
  - graphics_processor.sv
  - target: test
    files:
      - tb_gp_models.sv
      - tb_graphics_processor.sv

// ==== tb_graphics_processor.sv ====
// directed fill, line, fetch and stop tests for the graphics command processor
`timescale 1ns/1ns

module tb_graphics_processor
	import gp_cmd_pkg::*;
	import gp_mem_pkg::*;
();

	logic clk, rst, gp_valid, af_full, rdf_valid, le_ready, ff_ready;
	gp_word_t gp_code, le_color;
	gp_frame_t gp_frame, le_frame, ff_frame;
	gp_beat_t rdf_dout;
	logic af_wr_en, rdf_rd_en, le_color_valid, le_x0_valid, le_y0_valid;
	logic le_x1_valid, le_y1_valid, le_trigger, ff_valid;
	gp_block_addr_t af_addr_din;
	gp_coord_t le_point;
	gp_color_t ff_color;

	int value_errors = 0;
	int other_errors = 0;
	int cycles = 0;
	gp_word_t list_q[$];
	logic [67:0] want_q[$]; // expected engine events
	gp_frame_t frame_now;
	int stop_at;

	graphics_processor u_dut (.*);
	tb_dram_model u_dram (.*);
	tb_engine_model u_eng (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= 4000) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic check_color(string name, gp_color_t got, gp_color_t want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
			value_errors++;
		end
	endtask

	task automatic check_word(string name, gp_word_t got, gp_word_t want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
			value_errors++;
		end
	endtask

	task automatic check_coord(string name, gp_coord_t got, gp_coord_t want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, want);
			value_errors++;
		end
	endtask

	task automatic check_addr(string name, gp_block_addr_t got, gp_block_addr_t want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
			value_errors++;
		end
	endtask

	task automatic check_frame(string name, gp_frame_t got, gp_frame_t want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
			value_errors++;
		end
	endtask

	task automatic new_list(gp_frame_t frame);
		list_q.delete();
		want_q.delete();
		frame_now = frame;
		stop_at = -1;
	endtask

	task automatic add_fill(gp_color_t c);
		list_q.push_back({8'h01, c});
		want_q.push_back({4'd0, frame_now, 8'h00, c});
	endtask

	// command word followed by start and end point words
	task automatic add_line(gp_color_t c, gp_coord_t x0, gp_coord_t y0,
			gp_coord_t x1, gp_coord_t y1);
		list_q.push_back({8'h02, c});
		list_q.push_back({6'd0, x0, 6'd0, y0});
		list_q.push_back({6'd0, x1, 6'd0, y1});
		want_q.push_back({4'd1, frame_now, 8'h00, c});
		want_q.push_back({4'd2, frame_now, 22'd0, x0});
		want_q.push_back({4'd3, frame_now, 22'd0, y0});
		want_q.push_back({4'd4, frame_now, 22'd0, x1});
		want_q.push_back({4'd5, frame_now, 22'd0, y1});
		want_q.push_back({4'd6, frame_now, 32'd0});
	endtask

	task automatic add_stop();
		if (stop_at < 0)
			stop_at = list_q.size();
		list_q.push_back(32'h0000_0000);
	endtask

	task automatic run_list(gp_word_t code);
		logic [67:0] want, got;
		gp_block_addr_t addr;
		bit found;
		for (int i = 0; i < list_q.size(); i++)
			u_dram.mem[code[27:5] * 8 + i] = list_q[i];
		@(posedge clk);
		#1;
		gp_code = code;
		gp_frame = frame_now;
		gp_valid = 1'b1;
		@(posedge clk);
		#1;
		gp_valid = 1'b0;
		gp_code = ~code; // start fields are latched so these are ignored
		gp_frame = ~frame_now;
		@(posedge clk);
		#1;
		gp_valid = 1'b1; // second start while busy is ignored
		@(posedge clk);
		#1;
		gp_valid = 1'b0;
		do @(negedge clk); while (!u_dut.u_fetch.idle); // stop reached
		while (want_q.size() > 0) begin
			want = want_q.pop_front();
			u_eng.take_event(got, found);
			if (!found) begin
				$display("engine event of kind %0d never appeared", want[67:64]);
				other_errors++;
			end else if (got[67:64] != want[67:64]) begin
				$display("engine event kind %0d seen where kind %0d was due at %0t",
					got[67:64], want[67:64], $time);
				other_errors++;
			end else begin
				check_frame("frame", got[63:32], want[63:32]);
				case (want[67:64])
					4'd0: check_color("ff_color", got[23:0], want[23:0]);
					4'd1: check_word("le_color", got[31:0], want[31:0]);
					4'd6: ;
					default: check_coord("le_point", got[9:0], want[9:0]);
				endcase
			end
		end
		u_eng.take_event(got, found);
		if (found) begin
			$display("engine event of kind %0d appeared with none expected", got[67:64]);
			other_errors++;
		end
		for (int b = 0; b <= stop_at / GP_WORDS_PER_BLOCK; b++) begin
			u_dram.take_request(addr, found);
			if (!found) begin
				$display("block request %0d was never issued", b);
				other_errors++;
			end else begin
				check_addr("af_addr_din", addr,
					(gp_block_addr_t'(code[27:5]) << 2) + b * GP_ADDR_STEP);
			end
		end
		u_dram.take_request(addr, found);
		if (found) begin
			$display("block request at %h issued after the stop", addr);
			other_errors++;
		end
	endtask

	task automatic test_fills();
		new_list(32'h1000_0000);
		add_fill(24'h112233);
		add_fill(24'hff0080);
		add_fill(24'h00ff00);
		add_stop();
		run_list(32'h0000_0020);
	endtask

	task automatic test_lines();
		new_list(32'h2000_4000);
		add_line(24'habcdef, 10'd1, 10'd2, 10'd639, 10'd479);
		add_line(24'h010203, 10'd1023, 10'd0, 10'd0, 10'd1023);
		add_stop();
		run_list(32'h0000_0040);
	endtask

	// end point of the first line and start point of the second each open a new block
	task automatic test_boundary();
		new_list(32'h3000_0000);
		for (int i = 0; i < 6; i++)
			add_fill(24'h100000 + i);
		add_line(24'h445566, 10'd100, 10'd200, 10'd300, 10'd400);
		for (int i = 0; i < 6; i++)
			add_fill(24'h200000 + i);
		add_line(24'h778899, 10'd5, 10'd6, 10'd7, 10'd8);
		add_stop();
		run_list(32'h0000_0080);
	endtask

	task automatic test_stop_skip();
		new_list(32'h4000_0000);
		list_q.push_back(32'h7f12_3456);
		add_fill(24'h0a0b0c);
		list_q.push_back(32'h3300_0001);
		add_stop();
		for (int i = 0; i < 8; i++)
			list_q.push_back({8'h01, 24'hdead00 + i}); // must never run
		run_list(32'h0000_00c0);
	endtask

	task automatic test_backpressure();
		u_dram.stall_en = 1'b1;
		u_eng.stall_en = 1'b1;
		new_list(32'h5000_0000);
		add_fill(24'h123456);
		add_line(24'h654321, 10'd11, 10'd22, 10'd33, 10'd44);
		add_fill(24'h00aa55);
		add_fill(24'h00bb66);
		add_line(24'hc0ffee, 10'd512, 10'd256, 10'd128, 10'd64);
		add_stop();
		run_list(32'h0000_0100);
		new_list(32'h6000_8000);
		add_line(24'hfedcba, 10'd9, 10'd8, 10'd7, 10'd6);
		add_fill(24'h0f0f0f);
		add_stop();
		run_list(32'h0000_0180);
	endtask

	initial begin
		rst = 1'b1;
		gp_valid = 1'b0;
		gp_code = '0;
		gp_frame = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		test_fills();
		test_lines();
		test_boundary();
		test_stop_skip();
		test_backpressure();
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== tb_gp_models.sv ====
// testbench models of the dram read path and of the line engine and frame filler
`timescale 1ns/1ns

module tb_dram_model
	import gp_cmd_pkg::*;
	import gp_mem_pkg::*;
(
	input  logic           clk,
	input  logic           af_wr_en,
	input  gp_block_addr_t af_addr_din,
	input  logic           rdf_rd_en,
	output logic           af_full,
	output logic           rdf_valid,
	output gp_beat_t       rdf_dout
);

	gp_word_t mem [0:255];
	gp_block_addr_t req_q[$]; // accepted requests, oldest first
	bit stall_en = 1'b0;
	integer seed = 32'h32480386;
	int beats_left = 0;
	int delay = 0;
	int base = 0;

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hff00_0000 | i; // unknown opcode, tagged with its address
		af_full = 1'b0;
		rdf_valid = 1'b0;
		rdf_dout = '0;
	end

	always @(posedge clk) begin
		logic req_taken, beat_taken;
		gp_block_addr_t req_addr;
		int idx;
		req_taken = af_wr_en && !af_full;
		beat_taken = rdf_rd_en && rdf_valid;
		req_addr = af_addr_din;
		#1;
		if (req_taken) begin
			req_q.push_back(req_addr);
			base = req_addr * 2; // 4 address steps per 8 words
			beats_left = 2;
			delay = stall_en ? ($random(seed) & 3) : 0;
		end
		if (beat_taken) begin
			beats_left--;
			rdf_valid = 1'b0;
			delay = stall_en ? ($random(seed) & 3) : 0;
		end
		if (beats_left > 0 && !rdf_valid) begin
			if (delay > 0) begin
				delay--;
			end else begin
				idx = base + (2 - beats_left) * GP_WORDS_PER_BEAT;
				rdf_dout = {mem[idx+3], mem[idx+2], mem[idx+1], mem[idx]};
				rdf_valid = 1'b1;
			end
		end
		af_full = stall_en && (($random(seed) & 3) == 0);
	end

	task automatic take_request(output gp_block_addr_t addr, output bit found);
		found = req_q.size() > 0;
		addr = '0;
		if (found)
			addr = req_q.pop_front();
	endtask

endmodule

module tb_engine_model
	import gp_cmd_pkg::*;
(
	input  logic      clk,
	input  gp_word_t  le_color,
	input  gp_coord_t le_point,
	input  logic      le_color_valid,
	input  logic      le_x0_valid,
	input  logic      le_y0_valid,
	input  logic      le_x1_valid,
	input  logic      le_y1_valid,
	input  logic      le_trigger,
	input  gp_frame_t le_frame,
	input  logic      ff_valid,
	input  gp_color_t ff_color,
	input  gp_frame_t ff_frame,
	output logic      le_ready,
	output logic      ff_ready
);

	logic [67:0] obs_q[$]; // kind, frame, value
	bit stall_en = 1'b0;
	integer seed = 32'h32480386;
	int hold = 0;

	initial begin
		le_ready = 1'b1;
		ff_ready = 1'b1;
	end

	always @(negedge clk) begin
		if (ff_valid)
			obs_q.push_back({4'd0, ff_frame, 8'h00, ff_color});
		if (le_color_valid)
			obs_q.push_back({4'd1, le_frame, le_color});
		if (le_x0_valid)
			obs_q.push_back({4'd2, le_frame, 22'd0, le_point});
		if (le_y0_valid)
			obs_q.push_back({4'd3, le_frame, 22'd0, le_point});
		if (le_x1_valid)
			obs_q.push_back({4'd4, le_frame, 22'd0, le_point});
		if (le_y1_valid)
			obs_q.push_back({4'd5, le_frame, 22'd0, le_point});
		if (le_trigger)
			obs_q.push_back({4'd6, le_frame, 32'd0});
	end

	always @(posedge clk) begin
		logic trig;
		trig = le_trigger;
		#1;
		if (trig && stall_en)
			hold = ($random(seed) & 7) + 1; // busy drawing
		le_ready = (hold == 0);
		if (hold > 0)
			hold--;
		ff_ready = !(stall_en && (($random(seed) & 3) == 0));
	end

	task automatic take_event(output logic [67:0] ev, output bit found);
		found = obs_q.size() > 0;
		ev = '0;
		if (found)
			ev = obs_q.pop_front();
	endtask

endmodule

// ==== graphics_processor.sv ====
// graphics command processor top, latches the frame base and joins fetch, decode and execute
`timescale 1ns/1ns

module graphics_processor
	import gp_cmd_pkg::*;
	import gp_mem_pkg::*;
(
	input  logic           clk,
	input  logic           rst,
	input  gp_word_t       gp_code,
	input  gp_frame_t      gp_frame,
	input  logic           gp_valid,
	input  logic           af_full,
	input  logic           rdf_valid,
	input  gp_beat_t       rdf_dout,
	input  logic           le_ready,
	input  logic           ff_ready,
	output logic           af_wr_en,
	output gp_block_addr_t af_addr_din,
	output logic           rdf_rd_en,
	output gp_word_t       le_color,
	output gp_coord_t      le_point,
	output logic           le_color_valid,
	output logic           le_x0_valid,
	output logic           le_y0_valid,
	output logic           le_x1_valid,
	output logic           le_y1_valid,
	output logic           le_trigger,
	output gp_frame_t      le_frame,
	output logic           ff_valid,
	output gp_color_t      ff_color,
	output gp_frame_t      ff_frame
);

	gp_word_slot_t cur_slot;
	gp_decoded_t cur_cmd;
	logic word_take, halt;
	logic idle;
	gp_frame_t frame_base;

	// frame base only changes when a new list is started
	always_ff @(posedge clk) begin
		if (idle && gp_valid)
			frame_base <= gp_frame;
	end

	assign le_frame = frame_base;
	assign ff_frame = frame_base;

	gp_cmd_fetch u_fetch (
		.clk(clk), .rst(rst), .gp_code(gp_code), .gp_valid(gp_valid),
		.af_full(af_full), .rdf_valid(rdf_valid), .rdf_dout(rdf_dout),
		.word_take(word_take), .halt(halt), .af_wr_en(af_wr_en),
		.af_addr_din(af_addr_din), .rdf_rd_en(rdf_rd_en), .idle(idle),
		.cur_slot(cur_slot)
	);

	gp_cmd_decode u_decode (.cur_slot(cur_slot), .cur_cmd(cur_cmd));

	gp_cmd_execute u_execute (
		.clk(clk), .rst(rst), .cur_slot(cur_slot), .cur_cmd(cur_cmd),
		.le_ready(le_ready), .ff_ready(ff_ready), .word_take(word_take),
		.halt(halt), .le_color(le_color), .le_point(le_point),
		.le_color_valid(le_color_valid), .le_x0_valid(le_x0_valid),
		.le_y0_valid(le_y0_valid), .le_x1_valid(le_x1_valid),
		.le_y1_valid(le_y1_valid), .le_trigger(le_trigger),
		.ff_valid(ff_valid), .ff_color(ff_color)
	);

endmodule

// ==== gp_cmd_execute.sv ====
// command execute, dispatches fills and lines to the frame filler and line engine
`timescale 1ns/1ns

module gp_cmd_execute
	import gp_cmd_pkg::*;
	import gp_mem_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  gp_word_slot_t cur_slot,
	input  gp_decoded_t   cur_cmd,
	input  logic          le_ready,
	input  logic          ff_ready,
	output logic          word_take,
	output logic          halt,
	output gp_word_t      le_color,
	output gp_coord_t     le_point,
	output logic          le_color_valid,
	output logic          le_x0_valid,
	output logic          le_y0_valid,
	output logic          le_x1_valid,
	output logic          le_y1_valid,
	output logic          le_trigger,
	output logic          ff_valid,
	output gp_color_t     ff_color
);

	typedef enum logic [2:0] {
		e_dispatch,
		e_start_x,
		e_start_y,
		e_wait_end,
		e_end_x,
		e_end_y,
		e_trigger,
		e_wait_ready
	} exec_state_t;

	exec_state_t state, state_next;
	gp_coord_t pt_x, pt_y; // held point so y can follow x
	logic both_ready;
	logic fire_fill, fire_line, skip, pt_take;

	assign both_ready = le_ready && ff_ready;
	assign fire_fill = (state == e_dispatch) && cur_cmd.is_fill && both_ready;
	assign fire_line = (state == e_dispatch) && cur_cmd.is_line && both_ready;
	assign skip = (state == e_dispatch) && cur_slot.valid
		&& !(cur_cmd.is_stop || cur_cmd.is_fill || cur_cmd.is_line);
	// point words are taken in the start and end point states
	assign pt_take = cur_slot.valid
		&& (state == e_start_x || state == e_start_y || state == e_wait_end);

	assign word_take = fire_fill || fire_line || skip || pt_take;
	assign halt = (state == e_dispatch) && cur_cmd.is_stop; // stop is not popped

	always_comb begin
		state_next = state;
		case (state)
			e_dispatch:
				if (fire_line)
					state_next = e_start_x;
			e_start_x:
				if (cur_slot.valid)
					state_next = e_start_y;
			e_start_y:
				state_next = cur_slot.valid ? e_end_x : e_wait_end; // end word already here?
			e_wait_end:
				if (cur_slot.valid)
					state_next = e_end_x;
			e_end_x:
				state_next = e_end_y;
			e_end_y:
				state_next = e_trigger;
			e_trigger:
				state_next = e_wait_ready;
			e_wait_ready:
				if (le_ready)
					state_next = e_dispatch; // engine done drawing
			default:
				state_next = e_dispatch;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= e_dispatch;
			le_color_valid <= 1'b0;
			le_x0_valid <= 1'b0;
			le_y0_valid <= 1'b0;
			le_x1_valid <= 1'b0;
			le_y1_valid <= 1'b0;
			le_trigger <= 1'b0;
			ff_valid <= 1'b0;
		end else begin
			state <= state_next;
			le_color_valid <= fire_line;
			le_x0_valid <= (state == e_start_x) && cur_slot.valid;
			le_y0_valid <= (state == e_start_y);
			le_x1_valid <= (state == e_end_x);
			le_y1_valid <= (state == e_end_y);
			le_trigger <= (state == e_trigger);
			ff_valid <= fire_fill;
		end
	end

	always_ff @(posedge clk) begin
		if (fire_fill)
			ff_color <= cur_cmd.color;
		if (fire_line)
			le_color <= {8'h00, cur_cmd.color};
		if (pt_take) begin
			pt_x <= cur_cmd.x;
			pt_y <= cur_cmd.y;
		end
		case (state)
			e_start_x:
				le_point <= cur_cmd.x; // straight from the word
			e_start_y, e_end_y:
				le_point <= pt_y;
			e_end_x:
				le_point <= pt_x;
			default: ;
		endcase
	end

endmodule

// ==== gp_cmd_decode.sv ====
// command decode, splits the head word into opcode, colour and point fields
`timescale 1ns/1ns

module gp_cmd_decode
	import gp_cmd_pkg::*;
	import gp_mem_pkg::*;
(
	input  gp_word_slot_t cur_slot,
	output gp_decoded_t   cur_cmd
);

	gp_word_t word;
	gp_opcode_t opcode;

	assign word = cur_slot.word;
	assign opcode = gp_opcode_t'(word[GP_OPCODE_LSB +: $bits(gp_opcode_t)]);

	always_comb begin
		cur_cmd.opcode = opcode;
		cur_cmd.is_stop = 1'b0;
		cur_cmd.is_fill = 1'b0;
		cur_cmd.is_line = 1'b0;
		// only a word that is really present gets a class
		if (cur_slot.valid) begin
			case (opcode)
				op_stop:
					cur_cmd.is_stop = 1'b1;
				op_fill:
					cur_cmd.is_fill = 1'b1;
				op_line:
					cur_cmd.is_line = 1'b1;
				default: ; // unknown, left unclassified
			endcase
		end
		cur_cmd.color = word[GP_COLOR_LSB +: $bits(gp_color_t)];
		// point fields, meaningful when the word follows a line command
		cur_cmd.x = word[GP_X_LSB +: $bits(gp_coord_t)];
		cur_cmd.y = word[GP_Y_LSB +: $bits(gp_coord_t)];
	end

endmodule

// ==== gp_cmd_fetch.sv ====
// command fetch, requests 8-word blocks from dram and serves them one word at a time
`timescale 1ns/1ns

module gp_cmd_fetch
	import gp_cmd_pkg::*;
	import gp_mem_pkg::*;
(
	input  logic           clk,
	input  logic           rst,
	input  gp_word_t       gp_code,
	input  logic           gp_valid,
	input  logic           af_full,
	input  logic           rdf_valid,
	input  gp_beat_t       rdf_dout,
	input  logic           word_take,
	input  logic           halt,
	output logic           af_wr_en,
	output gp_block_addr_t af_addr_din,
	output logic           rdf_rd_en,
	output logic           idle,
	output gp_word_slot_t  cur_slot
);

	typedef enum logic [2:0] {
		f_idle,
		f_request,
		f_read_lo,
		f_read_hi,
		f_serve
	} fetch_state_t;

	typedef logic [3:0] word_count_t;

	fetch_state_t state, state_next;
	gp_block_addr_t blk_addr;
	logic [GP_WORDS_PER_BLOCK*$bits(gp_word_t)-1:0] words; // word 0 at the bottom
	word_count_t words_left;
	logic last_take;

	assign last_take = word_take && (words_left == word_count_t'(1));

	always_comb begin
		state_next = state;
		case (state)
			f_idle:
				if (gp_valid)
					state_next = f_request;
			f_request:
				if (!af_full)
					state_next = f_read_lo;
			f_read_lo:
				if (rdf_valid)
					state_next = f_read_hi;
			f_read_hi:
				if (rdf_valid)
					state_next = f_serve;
			f_serve: begin
				if (halt)
					state_next = f_idle;
				else if (last_take)
					state_next = f_request; // block used up, refill
			end
			default:
				state_next = f_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= f_idle;
			words_left <= '0;
		end else begin
			state <= state_next;
			if (state == f_read_hi && rdf_valid)
				words_left <= word_count_t'(GP_WORDS_PER_BLOCK);
			else if (state == f_serve && word_take)
				words_left <= words_left - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == f_idle && gp_valid)
			blk_addr <= {6'b000000, gp_code[27:5], 2'b00}; // list start
		else if (state == f_request && !af_full)
			blk_addr <= blk_addr + gp_block_addr_t'(GP_ADDR_STEP); // request taken
		if (state == f_read_lo && rdf_valid)
			words[0 +: $bits(gp_beat_t)] <= rdf_dout; // words 0..3
		else if (state == f_read_hi && rdf_valid)
			words[GP_WORDS_PER_BEAT*$bits(gp_word_t) +: $bits(gp_beat_t)] <= rdf_dout;
		else if (state == f_serve && word_take)
			words <= words >> $bits(gp_word_t); // pop head word
	end

	assign af_wr_en = (state == f_request);
	assign af_addr_din = blk_addr;
	assign rdf_rd_en = (state == f_read_lo) || (state == f_read_hi);
	assign idle = (state == f_idle);
	assign cur_slot.word = words[$bits(gp_word_t)-1:0];
	assign cur_slot.valid = (state == f_serve);

endmodule

// ==== gp_mem_pkg.sv ====
// memory side package, dram block addressing, read beats and the fetched word
package gp_mem_pkg;

	import gp_cmd_pkg::*;

	typedef logic [30:0] gp_block_addr_t; // dram request address
	typedef logic [127:0] gp_beat_t; // one read fifo beat

	// block geometry
	localparam int GP_WORDS_PER_BEAT = 4;
	localparam int GP_WORDS_PER_BLOCK = 8; // two beats per block
	localparam int GP_ADDR_STEP = 4; // address increment per block

	// word at the head of the fetch buffer
	typedef struct packed {
		gp_word_t word;
		logic valid;
	} gp_word_slot_t;

endpackage

// ==== gp_cmd_pkg.sv ====
// command format package, opcodes, field types and the decoded command
package gp_cmd_pkg;

	typedef logic [31:0] gp_word_t; // one command list word
	typedef logic [23:0] gp_color_t; // rgb, low 24 bits of a word
	typedef logic [9:0] gp_coord_t;
	typedef logic [31:0] gp_frame_t; // frame buffer base address

	// field positions inside a command or point word
	localparam int GP_OPCODE_LSB = 24;
	localparam int GP_COLOR_LSB = 0;
	localparam int GP_X_LSB = 16; // x in 25:16
	localparam int GP_Y_LSB = 0; // y in 9:0

	typedef enum logic [7:0] {
		op_stop = 8'h00,
		op_fill = 8'h01,
		op_line = 8'h02
	} gp_opcode_t;

	// one word seen both ways, as a command and as a point
	typedef struct packed {
		gp_opcode_t opcode;
		logic is_stop;
		logic is_fill;
		logic is_line;
		gp_color_t color;
		gp_coord_t x;
		gp_coord_t y;
	} gp_decoded_t;

endpackage
